// ==== rtl/mem_sub_defines.svh ====
// ====================
// Widths for a 32-bit system; source and sequence fields form a 4-bit ID
// ====================
`ifndef MEM_SUB_DEFINES_SVH
`define MEM_SUB_DEFINES_SVH

`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// ID layout is source then sequence
`define MEM_SRC_W 2
`define MEM_SEQ_W 2

`define MEM_MAX_OUTST 4

`define PF_STRIDE_W 16
`define PF_CNT_W 8

`endif

// ==== rtl/mem_req_pkg.sv ====
// ====================
// Request types; source codes must fit MEM_SRC_W
// ====================
`include "mem_sub_defines.svh"

package mem_req_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;

  // Source field value carried in every ID
  typedef enum logic [`MEM_SRC_W-1:0] {
    SRC_LOAD     = 2'd0,
    SRC_STORE    = 2'd1,
    SRC_PREFETCH = 2'd2
  } mem_src_e;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_src_e               src;
    logic [`MEM_SEQ_W-1:0]  seq;
  } mem_id_t;

endpackage

// ==== rtl/prefetch_pkg.sv ====
// ====================
// Prefetcher types; param sits in the low 17 bits of a 32-bit register
// ====================
`include "mem_sub_defines.svh"

package prefetch_pkg;

  // Enable in bit 16, stride in bits 15:0
  typedef struct packed {
    logic                    enable;
    logic [`PF_STRIDE_W-1:0] stride;
  } pf_param_t;

  typedef struct packed {
    logic                 busy;
    logic [`PF_CNT_W-1:0] issue_cnt;
  } pf_status_t;

  typedef enum logic {
    PF_IDLE    = 1'b0,
    PF_PENDING = 1'b1
  } pf_state_e;

endpackage

// ==== rtl/request_decode.sv ====
// ====================
// Holds one request; ready drops while full or at MEM_MAX_OUTST outstanding
// ====================
`include "mem_sub_defines.svh"

module request_decode #(
  parameter mem_req_pkg::mem_src_e SRC = mem_req_pkg::SRC_LOAD
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  mem_req_pkg::mem_addr_t req_addr_i,
  input  mem_req_pkg::mem_data_t req_wdata_i,
  input  logic                   grant_i,
  input  logic                   done_i,
  output logic                   src_valid_o,
  output mem_req_pkg::mem_op_e   src_op_o,
  output mem_req_pkg::mem_addr_t src_addr_o,
  output mem_req_pkg::mem_data_t src_wdata_o,
  output mem_req_pkg::mem_id_t   src_id_o,
  output logic                   idle_o
);

  localparam int cnt_w = $clog2(`MEM_MAX_OUTST + 1);

  logic                   hold_q, hold_d;
  logic                   ready_q;
  logic                   accept;
  logic [cnt_w-1:0]       outst_q, outst_d;
  logic [`MEM_SEQ_W-1:0]  seq_q;
  mem_req_pkg::mem_addr_t addr_q;
  mem_req_pkg::mem_data_t wdata_q;

  assign accept = req_valid_i & ready_q;

  always_comb begin
    hold_d  = hold_q;
    outst_d = outst_q;
    if (accept) begin
      hold_d = 1'b1;
    end else if (grant_i) begin
      hold_d = 1'b0;
    end
    // Grant and done in the same cycle cancel out
    if (grant_i && !done_i) begin
      outst_d = outst_q + 1'b1;
    end else if (done_i && !grant_i) begin
      outst_d = outst_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q  <= 1'b0;
      ready_q <= 1'b0;
      outst_q <= '0;
      seq_q   <= '0;
    end else begin
      hold_q  <= hold_d;
      ready_q <= !hold_d && (outst_d < `MEM_MAX_OUTST);
      outst_q <= outst_d;
      if (grant_i) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
  end

  assign req_ready_o  = ready_q;
  assign src_valid_o  = hold_q;
  assign src_op_o     = (SRC == mem_req_pkg::SRC_STORE) ? mem_req_pkg::MEM_WRITE
                                                        : mem_req_pkg::MEM_READ;
  assign src_addr_o   = addr_q;
  assign src_wdata_o  = wdata_q;
  assign src_id_o.src = SRC;
  assign src_id_o.seq = seq_q;
  assign idle_o       = !hold_q && (outst_q == '0);

endmodule

// ==== rtl/stride_prefetch.sv ====
// ====================
// Single stride stream; the stride is unsigned, so addresses only move up
// ====================
`include "mem_sub_defines.svh"

module stride_prefetch (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     base_set_i,
  input  mem_req_pkg::mem_addr_t   base_i,
  output mem_req_pkg::mem_addr_t   base_o,
  input  logic                     param_set_i,
  input  mem_req_pkg::mem_data_t   param_i,
  output mem_req_pkg::mem_data_t   param_o,
  output prefetch_pkg::pf_status_t status_o,
  input  logic                     snoop_valid_i,
  input  logic                     snoop_ready_i,
  input  mem_req_pkg::mem_addr_t   snoop_addr_i,
  output logic                     pf_valid_o,
  output mem_req_pkg::mem_addr_t   pf_addr_o,
  output mem_req_pkg::mem_id_t     pf_id_o,
  input  logic                     grant_i,
  input  logic                     done_i,
  output logic                     idle_o
);

  localparam int cnt_w = $clog2(`MEM_MAX_OUTST + 1);

  prefetch_pkg::pf_state_e state_q;
  prefetch_pkg::pf_param_t param_q;
  mem_req_pkg::mem_addr_t  base_q;
  mem_req_pkg::mem_addr_t  next_addr;
  mem_req_pkg::mem_addr_t  pf_addr_q;
  logic [`PF_CNT_W-1:0]    cnt_q;
  logic [`MEM_SEQ_W-1:0]   seq_q;
  logic [cnt_w-1:0]        outst_q;
  logic                    hit;

  assign next_addr = base_q + mem_req_pkg::mem_addr_t'(param_q.stride);

  // Only an accepted load at the base triggers, and only from idle
  assign hit = snoop_valid_i && snoop_ready_i && param_q.enable
            && (snoop_addr_i == base_q) && (state_q == prefetch_pkg::PF_IDLE)
            && (outst_q < `MEM_MAX_OUTST);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= prefetch_pkg::PF_IDLE;
      param_q <= '0;
      base_q  <= '0;
      cnt_q   <= '0;
      seq_q   <= '0;
      outst_q <= '0;
    end else begin
      if (param_set_i) begin
        param_q <= param_i[$bits(prefetch_pkg::pf_param_t)-1:0];
      end
      // A software write of the base wins over the stride update
      if (base_set_i) begin
        base_q <= base_i;
      end else if (hit) begin
        base_q <= next_addr;
      end
      if (hit) begin
        state_q <= prefetch_pkg::PF_PENDING;
      end else if (grant_i) begin
        state_q <= prefetch_pkg::PF_IDLE;
      end
      if (grant_i) begin
        cnt_q <= cnt_q + 1'b1;
        seq_q <= seq_q + 1'b1;
      end
      if (grant_i && !done_i) begin
        outst_q <= outst_q + 1'b1;
      end else if (done_i && !grant_i) begin
        outst_q <= outst_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit) begin
      pf_addr_q <= next_addr;
    end
  end

  assign base_o             = base_q;
  assign param_o            = mem_req_pkg::mem_data_t'(param_q);
  assign status_o.busy      = (state_q == prefetch_pkg::PF_PENDING) || (outst_q != '0);
  assign status_o.issue_cnt = cnt_q;
  assign pf_valid_o         = (state_q == prefetch_pkg::PF_PENDING);
  assign pf_addr_o          = pf_addr_q;
  assign pf_id_o.src        = mem_req_pkg::SRC_PREFETCH;
  assign pf_id_o.seq        = seq_q;
  assign idle_o             = !status_o.busy;

endmodule

// ==== rtl/request_arbiter.sv ====
// ====================
// Round robin over load, store, prefetch; a stalled choice stays locked
// ====================
module request_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   load_valid_i,
  input  mem_req_pkg::mem_op_e   load_op_i,
  input  mem_req_pkg::mem_addr_t load_addr_i,
  input  mem_req_pkg::mem_data_t load_wdata_i,
  input  mem_req_pkg::mem_id_t   load_id_i,
  output logic                   load_grant_o,
  input  logic                   store_valid_i,
  input  mem_req_pkg::mem_op_e   store_op_i,
  input  mem_req_pkg::mem_addr_t store_addr_i,
  input  mem_req_pkg::mem_data_t store_wdata_i,
  input  mem_req_pkg::mem_id_t   store_id_i,
  output logic                   store_grant_o,
  input  logic                   pf_valid_i,
  input  mem_req_pkg::mem_addr_t pf_addr_i,
  input  mem_req_pkg::mem_id_t   pf_id_i,
  output logic                   pf_grant_o,
  output logic                   mem_req_valid_o,
  input  logic                   mem_req_ready_i,
  output mem_req_pkg::mem_op_e   mem_req_op_o,
  output mem_req_pkg::mem_addr_t mem_req_addr_o,
  output mem_req_pkg::mem_data_t mem_req_wdata_o,
  output mem_req_pkg::mem_id_t   mem_req_id_o
);

  logic [2:0] req_vec;
  logic [1:0] ptr_q, rr_sel, sel, lock_sel_q;
  logic       lock_q;
  logic       handshake;

  assign req_vec = {pf_valid_i, store_valid_i, load_valid_i};

  // Scan from the pointer; the nearest requester wins
  always_comb begin
    logic [1:0] idx;
    rr_sel = ptr_q;
    for (int k = 2; k >= 0; k--) begin
      idx = 2'((int'(ptr_q) + k) % 3);
      if (req_vec[idx]) begin
        rr_sel = idx;
      end
    end
  end

  assign sel             = lock_q ? lock_sel_q : rr_sel;
  assign mem_req_valid_o = |req_vec;
  assign handshake       = mem_req_valid_o & mem_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else begin
      lock_q     <= mem_req_valid_o & !mem_req_ready_i;
      lock_sel_q <= sel;
      if (handshake) begin
        ptr_q <= (sel == 2'd2) ? 2'd0 : sel + 1'b1;
      end
    end
  end

  assign load_grant_o  = handshake && (sel == mem_req_pkg::SRC_LOAD);
  assign store_grant_o = handshake && (sel == mem_req_pkg::SRC_STORE);
  assign pf_grant_o    = handshake && (sel == mem_req_pkg::SRC_PREFETCH);

  always_comb begin
    mem_req_op_o    = mem_req_pkg::MEM_READ;
    mem_req_addr_o  = pf_addr_i;
    mem_req_wdata_o = '0;
    mem_req_id_o    = pf_id_i;
    case (sel)
      mem_req_pkg::SRC_LOAD: begin
        mem_req_op_o    = load_op_i;
        mem_req_addr_o  = load_addr_i;
        mem_req_wdata_o = load_wdata_i;
        mem_req_id_o    = load_id_i;
      end
      mem_req_pkg::SRC_STORE: begin
        mem_req_op_o    = store_op_i;
        mem_req_addr_o  = store_addr_i;
        mem_req_wdata_o = store_wdata_i;
        mem_req_id_o    = store_id_i;
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/response_route.sv ====
// ====================
// Responses are never stalled; flush_i must stay high until the acknowledge
// ====================
module response_route (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   mem_resp_valid_i,
  input  mem_req_pkg::mem_id_t   mem_resp_id_i,
  input  mem_req_pkg::mem_data_t mem_resp_rdata_i,
  output logic                   load_resp_valid_o,
  output mem_req_pkg::mem_data_t load_resp_rdata_o,
  output logic                   store_resp_valid_o,
  output logic                   load_done_o,
  output logic                   store_done_o,
  output logic                   pf_done_o,
  input  logic                   load_idle_i,
  input  logic                   store_idle_i,
  input  logic                   pf_idle_i,
  input  logic                   flush_i,
  output logic                   flush_ack_o
);

  logic                   load_valid_q;
  logic                   store_valid_q;
  logic                   flush_ack_q;
  mem_req_pkg::mem_data_t rdata_q;

  // Owner comes from the source field of the ID
  assign load_done_o  = mem_resp_valid_i && (mem_resp_id_i.src == mem_req_pkg::SRC_LOAD);
  assign store_done_o = mem_resp_valid_i && (mem_resp_id_i.src == mem_req_pkg::SRC_STORE);
  assign pf_done_o    = mem_resp_valid_i && (mem_resp_id_i.src == mem_req_pkg::SRC_PREFETCH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_valid_q  <= 1'b0;
      store_valid_q <= 1'b0;
      flush_ack_q   <= 1'b0;
    end else begin
      load_valid_q  <= load_done_o;
      store_valid_q <= store_done_o;
      flush_ack_q   <= flush_i && load_idle_i && store_idle_i && pf_idle_i && !flush_ack_q;
    end
  end

  // Prefetch data is dropped, only load data is kept
  always_ff @(posedge clk_i) begin
    if (load_done_o) begin
      rdata_q <= mem_resp_rdata_i;
    end
  end

  assign load_resp_valid_o  = load_valid_q;
  assign load_resp_rdata_o  = rdata_q;
  assign store_resp_valid_o = store_valid_q;
  assign flush_ack_o        = flush_ack_q;

endmodule

// ==== rtl/mem_sub_top.sv ====
// ====================
// All traffic goes to memory; one response is expected per request
// ====================
module mem_sub_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  output logic                     flush_ack_o,
  input  logic                     load_req_valid_i,
  output logic                     load_req_ready_o,
  input  mem_req_pkg::mem_addr_t   load_req_addr_i,
  output logic                     load_resp_valid_o,
  output mem_req_pkg::mem_data_t   load_resp_rdata_o,
  input  logic                     store_req_valid_i,
  output logic                     store_req_ready_o,
  input  mem_req_pkg::mem_addr_t   store_req_addr_i,
  input  mem_req_pkg::mem_data_t   store_req_wdata_i,
  output logic                     store_resp_valid_o,
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output mem_req_pkg::mem_op_e     mem_req_op_o,
  output mem_req_pkg::mem_addr_t   mem_req_addr_o,
  output mem_req_pkg::mem_data_t   mem_req_wdata_o,
  output mem_req_pkg::mem_id_t     mem_req_id_o,
  input  logic                     mem_resp_valid_i,
  input  mem_req_pkg::mem_id_t     mem_resp_id_i,
  input  mem_req_pkg::mem_data_t   mem_resp_rdata_i,
  input  logic                     hwpf_base_set_i,
  input  mem_req_pkg::mem_addr_t   hwpf_base_i,
  output mem_req_pkg::mem_addr_t   hwpf_base_o,
  input  logic                     hwpf_param_set_i,
  input  mem_req_pkg::mem_data_t   hwpf_param_i,
  output mem_req_pkg::mem_data_t   hwpf_param_o,
  output prefetch_pkg::pf_status_t hwpf_status_o
);

  logic                   load_valid, store_valid, pf_valid;
  logic                   load_grant, store_grant, pf_grant;
  logic                   load_done, store_done, pf_done;
  logic                   load_idle, store_idle, pf_idle;
  mem_req_pkg::mem_op_e   load_op, store_op;
  mem_req_pkg::mem_addr_t load_addr, store_addr, pf_addr;
  mem_req_pkg::mem_data_t load_wdata, store_wdata;
  mem_req_pkg::mem_id_t   load_id, store_id, pf_id;

  request_decode #(
    .SRC(mem_req_pkg::SRC_LOAD)
  ) load_decode_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (load_req_valid_i),
    .req_ready_o (load_req_ready_o),
    .req_addr_i  (load_req_addr_i),
    .req_wdata_i ('0),
    .grant_i     (load_grant),
    .done_i      (load_done),
    .src_valid_o (load_valid),
    .src_op_o    (load_op),
    .src_addr_o  (load_addr),
    .src_wdata_o (load_wdata),
    .src_id_o    (load_id),
    .idle_o      (load_idle)
  );

  request_decode #(
    .SRC(mem_req_pkg::SRC_STORE)
  ) store_decode_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (store_req_valid_i),
    .req_ready_o (store_req_ready_o),
    .req_addr_i  (store_req_addr_i),
    .req_wdata_i (store_req_wdata_i),
    .grant_i     (store_grant),
    .done_i      (store_done),
    .src_valid_o (store_valid),
    .src_op_o    (store_op),
    .src_addr_o  (store_addr),
    .src_wdata_o (store_wdata),
    .src_id_o    (store_id),
    .idle_o      (store_idle)
  );

  // Snoops the load port handshake directly
  stride_prefetch prefetch_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .base_set_i    (hwpf_base_set_i),
    .base_i        (hwpf_base_i),
    .base_o        (hwpf_base_o),
    .param_set_i   (hwpf_param_set_i),
    .param_i       (hwpf_param_i),
    .param_o       (hwpf_param_o),
    .status_o      (hwpf_status_o),
    .snoop_valid_i (load_req_valid_i),
    .snoop_ready_i (load_req_ready_o),
    .snoop_addr_i  (load_req_addr_i),
    .pf_valid_o    (pf_valid),
    .pf_addr_o     (pf_addr),
    .pf_id_o       (pf_id),
    .grant_i       (pf_grant),
    .done_i        (pf_done),
    .idle_o        (pf_idle)
  );

  request_arbiter arbiter_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .load_valid_i    (load_valid),
    .load_op_i       (load_op),
    .load_addr_i     (load_addr),
    .load_wdata_i    (load_wdata),
    .load_id_i       (load_id),
    .load_grant_o    (load_grant),
    .store_valid_i   (store_valid),
    .store_op_i      (store_op),
    .store_addr_i    (store_addr),
    .store_wdata_i   (store_wdata),
    .store_id_i      (store_id),
    .store_grant_o   (store_grant),
    .pf_valid_i      (pf_valid),
    .pf_addr_i       (pf_addr),
    .pf_id_i         (pf_id),
    .pf_grant_o      (pf_grant),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_op_o    (mem_req_op_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_id_o    (mem_req_id_o)
  );

  response_route route_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .mem_resp_valid_i   (mem_resp_valid_i),
    .mem_resp_id_i      (mem_resp_id_i),
    .mem_resp_rdata_i   (mem_resp_rdata_i),
    .load_resp_valid_o  (load_resp_valid_o),
    .load_resp_rdata_o  (load_resp_rdata_o),
    .store_resp_valid_o (store_resp_valid_o),
    .load_done_o        (load_done),
    .store_done_o       (store_done),
    .pf_done_o          (pf_done),
    .load_idle_i        (load_idle),
    .store_idle_i       (store_idle),
    .pf_idle_i          (pf_idle),
    .flush_i            (flush_i),
    .flush_ack_o        (flush_ack_o)
  );

endmodule

// ==== verification/mem_sub_tb_checks.svh ====
// ====================
// Included inside the testbench module; uses its per-kind error counters
// ====================

  task automatic check_data(input string name, input mem_req_pkg::mem_data_t exp,
                            input mem_req_pkg::mem_data_t act);
    if (act !== exp) begin
      err_data++;
      $display("error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input mem_req_pkg::mem_addr_t exp,
                            input mem_req_pkg::mem_addr_t act);
    if (act !== exp) begin
      err_addr++;
      $display("error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_src(input string name, input mem_req_pkg::mem_src_e exp,
                           input mem_req_pkg::mem_src_e act);
    if (act !== exp) begin
      err_src++;
      $display("error %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Sequence field wraps with the ID width
  task automatic check_seq(input string name, input logic [`MEM_SEQ_W-1:0] exp,
                           input logic [`MEM_SEQ_W-1:0] act);
    if (act !== exp) begin
      err_seq++;
      $display("error %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input prefetch_pkg::pf_status_t exp,
                              input prefetch_pkg::pf_status_t act);
    if (act !== exp) begin
      err_status++;
      $display("error %s: expected busy %0b count %0d actual busy %0b count %0d",
               name, exp.busy, exp.issue_cnt, act.busy, act.issue_cnt);
    end
  endtask

// ==== verification/mem_sub_tb.sv ====
// ====================
// Run from the project root since the trace path is relative to it
// ====================
`include "mem_sub_defines.svh"

module mem_sub_tb;

  logic                     clk_i, rst_ni, flush_i, flush_ack_o;
  logic                     load_req_valid_i, load_req_ready_o, load_resp_valid_o;
  mem_req_pkg::mem_addr_t   load_req_addr_i;
  mem_req_pkg::mem_data_t   load_resp_rdata_o;
  logic                     store_req_valid_i, store_req_ready_o, store_resp_valid_o;
  mem_req_pkg::mem_addr_t   store_req_addr_i;
  mem_req_pkg::mem_data_t   store_req_wdata_i;
  logic                     mem_req_valid_o, mem_req_ready_i, mem_resp_valid_i;
  mem_req_pkg::mem_op_e     mem_req_op_o;
  mem_req_pkg::mem_addr_t   mem_req_addr_o;
  mem_req_pkg::mem_data_t   mem_req_wdata_o, mem_resp_rdata_i;
  mem_req_pkg::mem_id_t     mem_req_id_o, mem_resp_id_i;
  logic                     hwpf_base_set_i, hwpf_param_set_i;
  mem_req_pkg::mem_addr_t   hwpf_base_i, hwpf_base_o;
  mem_req_pkg::mem_data_t   hwpf_param_i, hwpf_param_o;
  prefetch_pkg::pf_status_t hwpf_status_o;

  integer                 seed = 32'h914c;
  int                     err_data, err_addr, err_src, err_seq, err_status, err_other;
  int                     n_ops, cycle, flush_cnt, ack_cnt, store_pending, pf_cnt_exp;
  logic                   trace_ready = 1'b0;
  logic [`MEM_SEQ_W-1:0]  load_seq = '0;
  logic [`MEM_SEQ_W-1:0]  store_seq = '0;
  logic [`MEM_SEQ_W-1:0]  pf_seq = '0;
  mem_req_pkg::mem_addr_t pf_base_exp = '0;
  byte                    op_q[$];
  mem_req_pkg::mem_addr_t arg_a_q[$], arg_b_q[$], arg_c_q[$];
  mem_req_pkg::mem_addr_t ld_addr_q[$], st_addr_q[$], pf_addr_q[$];
  mem_req_pkg::mem_data_t ld_data_q[$], st_data_q[$];
  mem_req_pkg::mem_id_t   resp_id_q[$];
  mem_req_pkg::mem_data_t resp_data_q[$];
  int                     resp_due_q[$];
  mem_req_pkg::mem_data_t wmem [mem_req_pkg::mem_addr_t];

  `include "mem_sub_tb_checks.svh"

  mem_sub_top mem_sub_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic print_error_counts();
    $display("errors: data %0d, addr %0d, src %0d, seq %0d, status %0d, other %0d",
             err_data, err_addr, err_src, err_seq, err_status, err_other);
  endtask

  task automatic issue_load(input mem_req_pkg::mem_addr_t addr,
                            input mem_req_pkg::mem_data_t exp);
    load_req_valid_i = 1'b1;
    load_req_addr_i  = addr;
    while (!load_req_ready_o) @(negedge clk_i);
    ld_addr_q.push_back(addr);
    ld_data_q.push_back(exp);
    @(negedge clk_i);
    load_req_valid_i = 1'b0;
  endtask

  task automatic issue_store(input mem_req_pkg::mem_addr_t addr,
                             input mem_req_pkg::mem_data_t data);
    store_req_valid_i = 1'b1;
    store_req_addr_i  = addr;
    store_req_wdata_i = data;
    while (!store_req_ready_o) @(negedge clk_i);
    st_addr_q.push_back(addr);
    st_data_q.push_back(data);
    store_pending++;
    @(negedge clk_i);
    store_req_valid_i = 1'b0;
  endtask

  task automatic configure_prefetch(input mem_req_pkg::mem_addr_t base,
                                    input mem_req_pkg::mem_data_t stride,
                                    input mem_req_pkg::mem_addr_t exp_addr);
    mem_req_pkg::mem_data_t param;
    // Enable in bit 16 above the stride
    param            = 32'h0001_0000 | {16'h0, stride[15:0]};
    hwpf_base_set_i  = 1'b1;
    hwpf_base_i      = base;
    hwpf_param_set_i = 1'b1;
    hwpf_param_i     = param;
    @(negedge clk_i);
    hwpf_base_set_i  = 1'b0;
    hwpf_param_set_i = 1'b0;
    check_addr("prefetch base readback", base, hwpf_base_o);
    check_data("prefetch param readback", param, hwpf_param_o);
    pf_addr_q.push_back(exp_addr);
    pf_base_exp = exp_addr;
    pf_cnt_exp++;
  endtask

  task automatic do_flush();
    prefetch_pkg::pf_status_t exp_status;
    flush_i = 1'b1;
    @(negedge clk_i);
    while (!flush_ack_o) @(negedge clk_i);
    flush_i = 1'b0;
    flush_cnt++;
    if (ld_addr_q.size() + ld_data_q.size() + st_addr_q.size() + pf_addr_q.size() != 0
        || store_pending != 0 || resp_due_q.size() != 0) begin
      err_other++;
      $display("flush acknowledged while requests or responses were still outstanding");
    end
    exp_status.busy      = 1'b0;
    exp_status.issue_cnt = pf_cnt_exp[`PF_CNT_W-1:0];
    check_status("prefetch status after flush", exp_status, hwpf_status_o);
    check_addr("prefetch base after stride", pf_base_exp, hwpf_base_o);
    repeat (2) @(negedge clk_i);
    if (ack_cnt != flush_cnt) begin
      err_other++;
      $display("saw %0d flush acknowledges for %0d flushes", ack_cnt, flush_cnt);
    end
  endtask

  // Classify by opcode and source, then match against the per-source order
  task automatic check_request();
    if (mem_req_op_o == mem_req_pkg::MEM_WRITE) begin
      check_src("store request source", mem_req_pkg::SRC_STORE, mem_req_id_o.src);
      check_seq("store request sequence", store_seq, mem_req_id_o.seq);
      store_seq++;
      wmem[mem_req_addr_o] = mem_req_wdata_o;
      if (st_addr_q.size() == 0) begin
        err_other++;
        $display("memory write seen with no store outstanding");
      end else begin
        check_addr("store request address", st_addr_q.pop_front(), mem_req_addr_o);
        check_data("store request data", st_data_q.pop_front(), wmem[mem_req_addr_o]);
      end
    end else if (mem_req_id_o.src == mem_req_pkg::SRC_PREFETCH) begin
      check_seq("prefetch request sequence", pf_seq, mem_req_id_o.seq);
      pf_seq++;
      if (pf_addr_q.size() == 0) begin
        err_other++;
        $display("prefetch read seen with no prefetch expected");
      end else begin
        check_addr("prefetch request address", pf_addr_q.pop_front(), mem_req_addr_o);
      end
    end else begin
      check_src("load request source", mem_req_pkg::SRC_LOAD, mem_req_id_o.src);
      check_seq("load request sequence", load_seq, mem_req_id_o.seq);
      load_seq++;
      if (ld_addr_q.size() == 0) begin
        err_other++;
        $display("memory read seen with no load outstanding");
      end else begin
        check_addr("load request address", ld_addr_q.pop_front(), mem_req_addr_o);
      end
    end
  endtask

  // In-order memory responses after 1 to 6 cycles
  always @(negedge clk_i) begin : mem_model
    int due;
    cycle++;
    mem_req_ready_i = (($random(seed) & 3) != 0);
    if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle) begin
      mem_resp_valid_i = 1'b1;
      mem_resp_id_i    = resp_id_q.pop_front();
      mem_resp_rdata_i = resp_data_q.pop_front();
      due              = resp_due_q.pop_front();
    end else begin
      mem_resp_valid_i = 1'b0;
    end
    if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
      due = cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 6);
      if (resp_due_q.size() > 0 && due <= resp_due_q[$]) begin
        due = resp_due_q[$] + 1;
      end
      resp_id_q.push_back(mem_req_id_o);
      resp_data_q.push_back(~mem_req_addr_o);
      resp_due_q.push_back(due);
      check_request();
    end
  end

  always @(negedge clk_i) begin : port_monitor
    if (load_resp_valid_o) begin
      if (ld_data_q.size() == 0) begin
        err_other++;
        $display("load response seen with no load outstanding");
      end else begin
        check_data("load response data", ld_data_q.pop_front(), load_resp_rdata_o);
      end
    end
    if (store_resp_valid_o) begin
      if (store_pending == 0) begin
        err_other++;
        $display("store acknowledge seen with no store outstanding");
      end else begin
        store_pending--;
      end
    end
    if (flush_ack_o) begin
      ack_cnt++;
    end
  end

  initial begin
    wait (trace_ready);
    repeat (n_ops * 200) @(posedge clk_i);
    $display("timeout after %0d cycles, the trace did not finish", n_ops * 200);
    print_error_counts();
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int                     fd;
    int                     code;
    string                  line;
    byte                    op;
    mem_req_pkg::mem_addr_t a, b, c;
    rst_ni            = 1'b0;
    flush_i           = 1'b0;
    load_req_valid_i  = 1'b0;
    load_req_addr_i   = '0;
    store_req_valid_i = 1'b0;
    store_req_addr_i  = '0;
    store_req_wdata_i = '0;
    mem_req_ready_i   = 1'b0;
    mem_resp_valid_i  = 1'b0;
    mem_resp_id_i     = '0;
    mem_resp_rdata_i  = '0;
    hwpf_base_set_i   = 1'b0;
    hwpf_base_i       = '0;
    hwpf_param_set_i  = 1'b0;
    hwpf_param_i      = '0;
    fd = $fopen("verification/mem_sub_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file verification/mem_sub_trace.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line[0] != "#" && line[0] != "\n") begin
          code = $sscanf(line, "%c %h %h %h", op, a, b, c);
          op_q.push_back(op);
          arg_a_q.push_back(a);
          arg_b_q.push_back(b);
          arg_c_q.push_back(c);
        end
      end
      $fclose(fd);
      n_ops       = op_q.size();
      trace_ready = 1'b1;
      repeat (2) @(negedge clk_i);
      rst_ni = 1'b1;
      foreach (op_q[i]) begin
        case (op_q[i])
          "L": issue_load(arg_a_q[i], arg_b_q[i]);
          "S": issue_store(arg_a_q[i], arg_b_q[i]);
          "P": configure_prefetch(arg_a_q[i], arg_b_q[i], arg_c_q[i]);
          "F": do_flush();
          default: begin
            err_other++;
            $display("unknown trace operation on line %0d", i);
          end
        endcase
      end
      repeat (4) @(negedge clk_i);
      print_error_counts();
      if (err_data + err_addr + err_src + err_seq + err_status + err_other == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

// ==== project.f ====
+incdir+rtl
+incdir+verification
rtl/mem_req_pkg.sv
rtl/prefetch_pkg.sv
rtl/request_decode.sv
rtl/stride_prefetch.sv
rtl/request_arbiter.sv
rtl/response_route.sv
rtl/mem_sub_top.sv
verification/mem_sub_tb.sv

// ==== verification/mem_sub_trace.txt ====
# L <addr> <expected load data> | S <addr> <write data> | F flush
# P <base> <stride> <expected prefetch address>, the next load to the base triggers it
L 00001000 ffffefff
L 00001004 ffffeffb
S 00002000 cafe0001
L 00001008 ffffeff7
S 00002004 cafe0002
F
P 00003000 00000040 00003040
L 00003000 ffffcfff
F
S 00002008 cafe0003
L 0000100c ffffeff3
S 0000200c cafe0004
L 00001010 ffffefef
L 00001014 ffffefeb
S 00002010 cafe0005
F
P 00004000 00000100 00004100
L 00004000 ffffbfff
L 00001018 ffffefe7
S 00002014 cafe0006
F
